// ==== src/rvExecPkg.sv ====
`default_nettype none

package rvExecPkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    localparam int XLEN      = 32;    // rv32i data path
    localparam int REG_COUNT = 32;    // x0 .. x31
    localparam int REG_SEL_W = 5;     // bits to pick one of REG_COUNT

    // funct7 patterns seen in OP / OP-IMM shifts
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra, srai

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // reg-reg
        OPC_OP_IMM = 7'b0010011,    // reg-imm
        OPC_LUI    = 7'b0110111     // upper immediate
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10           // lui, operand b straight through
    } aluOp_e;

    // ------------------------------------------------------------------------
    // records
    // ------------------------------------------------------------------------

    // decoder output, 54 bits
    typedef struct packed {
        logic [REG_SEL_W-1:0] rs1;
        logic [REG_SEL_W-1:0] rs2;
        logic [REG_SEL_W-1:0] rd;
        logic [XLEN-1:0]      imm;      // sign extended I or U immediate
        aluOp_e               aluOp;
        logic                 useImm;   // operand b from imm
        logic                 writeEn;  // result goes to rd
        logic                 illegal;  // unsupported encoding
    } decodedInstr_t;

    // writeback record, 37 bits
    typedef struct packed {
        logic [REG_SEL_W-1:0] rd;
        logic [XLEN-1:0]      data;
    } writeback_t;

endpackage

`default_nettype wire

// ==== src/RegisterFile.sv ====
`default_nettype none
`timescale 1ns/1ps

// 32 x 32 integer register bank, two read ports and one write port
module RegisterFile (
    input  logic                                clk_i,
    input  logic                                regWe_i,    // active low
    input  logic [rvExecPkg::XLEN-1:0]      data_i,     // write data
    input  logic [rvExecPkg::REG_SEL_W-1:0] regDst_i,   // write select
    input  logic [rvExecPkg::REG_SEL_W-1:0] regSrcA_i,  // read port a select
    input  logic [rvExecPkg::REG_SEL_W-1:0] regSrcB_i,  // read port b select
    output logic [rvExecPkg::XLEN-1:0]      srcA_o,
    output logic [rvExecPkg::XLEN-1:0]      srcB_o
);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------

    logic [rvExecPkg::XLEN-1:0] bank [0:rvExecPkg::REG_COUNT-1];

    logic writeHit;     // enabled write to a real register

    assign writeHit = !regWe_i && (regDst_i != '0);

    // falling edge write so the next instruction reads it
    always_ff @(negedge clk_i) begin
        if (writeHit) begin
            bank[regDst_i] <= data_i;
        end
    end

    // ------------------------------------------------------------------------
    // reads
    // ------------------------------------------------------------------------

    // x0 reads as zero whatever the bank holds
    assign srcA_o = (regSrcA_i == '0) ? '0 : bank[regSrcA_i];
    assign srcB_o = (regSrcB_i == '0) ? '0 : bank[regSrcB_i];

    // an enabled write must carry known data, otherwise the bank is poisoned
    // and every later reader inherits it
    writeDataKnown: assert property (
        @(negedge clk_i) !regWe_i |-> !$isunknown(data_i)
    ) else $error("register write with unknown data, rd=%0d", regDst_i);

endmodule

`default_nettype wire

// ==== src/InstructionDecoder.sv ====
`default_nettype none
`timescale 1ns/1ps

// rv32i decode for OP, OP-IMM and LUI
module InstructionDecoder (
    input  logic [rvExecPkg::XLEN-1:0] instr_i,
    output rvExecPkg::decodedInstr_t   decoded_o
);

    // ------------------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------------------

    rvExecPkg::opcode_e         opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic                       f7Base;     // funct7 all zero
    logic                       f7Alt;      // funct7 = 0100000
    logic [rvExecPkg::XLEN-1:0] immI;       // sign extended instr[31:20]
    logic [rvExecPkg::XLEN-1:0] immU;       // instr[31:12] << 12

    assign opcode = rvExecPkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign f7Base = (funct7 == rvExecPkg::F7_BASE);
    assign f7Alt  = (funct7 == rvExecPkg::F7_ALT);

    assign immI = {{(rvExecPkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign immU = {instr_i[31:12], 12'b0};

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------

    always_comb begin
        decoded_o         = '0;
        decoded_o.rs1     = instr_i[19:15];
        decoded_o.rs2     = instr_i[24:20];
        decoded_o.rd      = instr_i[11:7];
        decoded_o.aluOp   = rvExecPkg::ALU_ADD;

        case (opcode)
            rvExecPkg::OPC_OP: begin
                decoded_o.writeEn = 1'b1;   // every supported op writes rd
                case (funct3)
                    3'b000: decoded_o.aluOp = f7Alt ? rvExecPkg::ALU_SUB : rvExecPkg::ALU_ADD;
                    3'b001: decoded_o.aluOp = rvExecPkg::ALU_SLL;
                    3'b010: decoded_o.aluOp = rvExecPkg::ALU_SLT;
                    3'b011: decoded_o.aluOp = rvExecPkg::ALU_SLTU;
                    3'b100: decoded_o.aluOp = rvExecPkg::ALU_XOR;
                    3'b101: decoded_o.aluOp = f7Alt ? rvExecPkg::ALU_SRA : rvExecPkg::ALU_SRL;
                    3'b110: decoded_o.aluOp = rvExecPkg::ALU_OR;
                    3'b111: decoded_o.aluOp = rvExecPkg::ALU_AND;
                endcase
                // alt funct7 only legal on add/sub and srl/sra
                if (!(f7Base || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
                    decoded_o.illegal = 1'b1;
                    decoded_o.writeEn = 1'b0;
                end
            end
            rvExecPkg::OPC_OP_IMM: begin
                decoded_o.useImm  = 1'b1;
                decoded_o.writeEn = 1'b1;
                decoded_o.imm     = immI;
                decoded_o.rs2     = '0;     // field is immediate bits here
                case (funct3)
                    3'b000: decoded_o.aluOp = rvExecPkg::ALU_ADD;
                    3'b001: begin
                        decoded_o.aluOp   = rvExecPkg::ALU_SLL;
                        decoded_o.illegal = !f7Base;    // slli upper bits must be zero
                        decoded_o.writeEn = f7Base;
                    end
                    3'b010: decoded_o.aluOp = rvExecPkg::ALU_SLT;
                    3'b011: decoded_o.aluOp = rvExecPkg::ALU_SLTU;
                    3'b100: decoded_o.aluOp = rvExecPkg::ALU_XOR;
                    3'b101: begin
                        decoded_o.aluOp   = f7Alt ? rvExecPkg::ALU_SRA : rvExecPkg::ALU_SRL;
                        decoded_o.illegal = !(f7Base || f7Alt);
                        decoded_o.writeEn = f7Base || f7Alt;
                    end
                    3'b110: decoded_o.aluOp = rvExecPkg::ALU_OR;
                    3'b111: decoded_o.aluOp = rvExecPkg::ALU_AND;
                endcase
            end
            rvExecPkg::OPC_LUI: begin
                decoded_o.aluOp   = rvExecPkg::ALU_PASSB;
                decoded_o.useImm  = 1'b1;
                decoded_o.writeEn = 1'b1;
                decoded_o.imm     = immU;
                decoded_o.rs1     = '0;     // no register sources
                decoded_o.rs2     = '0;
            end
            default: begin
                decoded_o.illegal = 1'b1;   // load, store, branch, ... not handled
            end
        endcase
    end

    // a decode that writes and traps at once would corrupt the bank
    always_comb begin
        noWriteOnIllegal: assert (!(decoded_o.illegal && decoded_o.writeEn))
            else $error("illegal instruction decoded with write enable");
    end

endmodule

`default_nettype wire

// ==== src/IntegerAlu.sv ====
`default_nettype none
`timescale 1ns/1ps

// rv32i integer alu, purely combinational
module IntegerAlu (
    input  rvExecPkg::aluOp_e          aluOp_i,
    input  logic [rvExecPkg::XLEN-1:0] opA_i,
    input  logic [rvExecPkg::XLEN-1:0] opB_i,
    output logic [rvExecPkg::XLEN-1:0] result_o
);

    // ------------------------------------------------------------------------
    // shared terms
    // ------------------------------------------------------------------------

    logic [$clog2(rvExecPkg::XLEN)-1:0] shamt;  // low bits of b only
    logic [rvExecPkg::XLEN-1:0]         sum;
    logic [rvExecPkg::XLEN-1:0]         diff;
    logic                               ltSigned;
    logic                               ltUnsigned;

    assign shamt      = opB_i[$clog2(rvExecPkg::XLEN)-1:0];
    assign sum        = opA_i + opB_i;
    assign diff       = opA_i - opB_i;
    assign ltSigned   = $signed(opA_i) < $signed(opB_i);
    assign ltUnsigned = opA_i < opB_i;

    // ------------------------------------------------------------------------
    // result select
    // ------------------------------------------------------------------------

    always_comb begin
        case (aluOp_i)
            rvExecPkg::ALU_ADD:   result_o = sum;
            rvExecPkg::ALU_SUB:   result_o = diff;
            rvExecPkg::ALU_SLL:   result_o = opA_i << shamt;
            rvExecPkg::ALU_SLT: begin
                result_o = {{(rvExecPkg::XLEN-1){1'b0}}, ltSigned};
            end
            rvExecPkg::ALU_SLTU: begin
                result_o = {{(rvExecPkg::XLEN-1){1'b0}}, ltUnsigned};
            end
            rvExecPkg::ALU_XOR:   result_o = opA_i ^ opB_i;
            rvExecPkg::ALU_SRL:   result_o = opA_i >> shamt;      // zero fill
            rvExecPkg::ALU_SRA:   result_o = $signed(opA_i) >>> shamt;  // sign fill
            rvExecPkg::ALU_OR:    result_o = opA_i | opB_i;
            rvExecPkg::ALU_AND:   result_o = opA_i & opB_i;
            rvExecPkg::ALU_PASSB: result_o = opB_i;               // lui
            default:              result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/ExecuteUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

// execute subsystem top, decode -> regfile read -> alu -> regfile write
module ExecuteUnit (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       instrValid_i,
    input  logic [rvExecPkg::XLEN-1:0] instr_i,
    output logic                       wbValid_o,
    output rvExecPkg::writeback_t      wb_o,
    output logic                       illegal_o
);

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    rvExecPkg::decodedInstr_t   decoded;
    logic [rvExecPkg::XLEN-1:0] srcA;
    logic [rvExecPkg::XLEN-1:0] srcB;
    logic [rvExecPkg::XLEN-1:0] opB;
    logic [rvExecPkg::XLEN-1:0] aluResult;
    logic                       writeActive;    // valid, legal, writing
    logic                       regWe;          // active low to regfile
    rvExecPkg::writeback_t      wbHold;         // result caught at the write edge

    InstructionDecoder InstructionDecoder_inst (
        .instr_i   (instr_i),
        .decoded_o (decoded)
    );

    RegisterFile RegisterFile_inst (
        .clk_i     (clk_i),
        .regWe_i   (regWe),
        .data_i    (aluResult),
        .regDst_i  (decoded.rd),
        .regSrcA_i (decoded.rs1),
        .regSrcB_i (decoded.rs2),
        .srcA_o    (srcA),
        .srcB_o    (srcB)
    );

    assign opB = decoded.useImm ? decoded.imm : srcB;

    IntegerAlu IntegerAlu_inst (
        .aluOp_i  (decoded.aluOp),
        .opA_i    (srcA),
        .opB_i    (opB),
        .result_o (aluResult)
    );

    // decoder clears writeEn on any illegal word
    assign writeActive = instrValid_i && decoded.writeEn;
    assign regWe       = !writeActive;

    // after the falling edge write, rd == rs reads the new value, so the
    // alu output no longer matches what was written; hold it here
    always_ff @(negedge clk_i) begin
        wbHold.rd   <= decoded.rd;
        wbHold.data <= aluResult;
    end

    // ------------------------------------------------------------------------
    // writeback record, one cycle behind the instruction
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wbValid_o <= 1'b0;
            illegal_o <= 1'b0;
            wb_o      <= '0;
        end else begin
            wbValid_o <= writeActive;               // rd = 0 included
            illegal_o <= instrValid_i && decoded.illegal;
            if (writeActive) begin
                wb_o <= wbHold;
            end
        end
    end

    // a trap and a writeback for the same slot would mean decode and
    // write enable disagree
    wbOrTrap: assert property (
        @(posedge clk_i) disable iff (rst_i) !(wbValid_o && illegal_o)
    ) else $error("wbValid_o and illegal_o high together");

endmodule

`default_nettype wire

// ==== verif/ExecuteUnitTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module ExecuteUnitTb;

    // ------------------------------------------------------------------------
    // timing, budget, expected slot kinds
    // ------------------------------------------------------------------------

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int TOTAL_INSTR  = 320;  // all tests together, rounded up
    localparam int WATCHDOG_NS  = TOTAL_INSTR * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD;
    localparam int EXP_IDLE     = 0;    // no output expected
    localparam int EXP_WRITE    = 1;    // wbValid_o with a record
    localparam int EXP_TRAP     = 2;    // illegal_o only

    logic                  clk;
    logic                  rst;
    logic                  instrValid;
    logic [31:0]           instr;
    logic                  wbValid;
    rvExecPkg::writeback_t wb;
    logic                  illegal;

    logic [31:0]           model [0:31];    // reference register bank
    logic [31:0]           rngState;
    int                    errCount;
    int                    checkCount;
    string                 testName;
    int                    pendKind;        // what the next output slot must hold
    rvExecPkg::writeback_t pendWb;
    string                 pendName;

    ExecuteUnit ExecuteUnit_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .instrValid_i (instrValid),
        .instr_i      (instr),
        .wbValid_o    (wbValid),
        .wb_o         (wb),
        .illegal_o    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reference model and encoders
    // ------------------------------------------------------------------------

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [4:0] randReg();     // x1 .. x31
        logic [31:0] v;
        v = nextRand();
        return 5'(v % 32'd31) + 5'd1;
    endfunction

    function automatic logic [31:0] aluModel(input rvExecPkg::aluOp_e op,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            rvExecPkg::ALU_ADD:   return a + b;
            rvExecPkg::ALU_SUB:   return a + ~b + 32'd1;    // two's complement
            rvExecPkg::ALU_SLL:   return a << s;
            rvExecPkg::ALU_SLT:   return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            rvExecPkg::ALU_SLTU:  return {31'b0, a < b};
            rvExecPkg::ALU_XOR:   return a ^ b;
            rvExecPkg::ALU_SRL:   return a >> s;
            rvExecPkg::ALU_SRA:   return (a >> s) | (a[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0);
            rvExecPkg::ALU_OR:    return a | b;
            rvExecPkg::ALU_AND:   return a & b;
            rvExecPkg::ALU_PASSB: return b;
            default:              return 32'h0;
        endcase
    endfunction

    // spec funct3 / funct7 for each operation
    function automatic logic [2:0] funct3Of(input rvExecPkg::aluOp_e op);
        case (op)
            rvExecPkg::ALU_SLL:                    return 3'b001;
            rvExecPkg::ALU_SLT:                    return 3'b010;
            rvExecPkg::ALU_SLTU:                   return 3'b011;
            rvExecPkg::ALU_XOR:                    return 3'b100;
            rvExecPkg::ALU_SRL, rvExecPkg::ALU_SRA: return 3'b101;
            rvExecPkg::ALU_OR:                     return 3'b110;
            rvExecPkg::ALU_AND:                    return 3'b111;
            default:                               return 3'b000;  // add, sub
        endcase
    endfunction

    function automatic logic [6:0] funct7Of(input rvExecPkg::aluOp_e op);
        return (op == rvExecPkg::ALU_SUB || op == rvExecPkg::ALU_SRA) ? 7'b0100000 : 7'b0;
    endfunction

    function automatic logic [31:0] encodeR(input rvExecPkg::aluOp_e op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        return {funct7Of(op), rs2, rs1, funct3Of(op), rd, rvExecPkg::OPC_OP};
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic checkFlag(input string name, input string what,
                             input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("Mismatch %s: %s expected %0b actual %0b", name, what, expected, actual);
        end
    endtask

    task automatic checkWriteback(input string name, input rvExecPkg::writeback_t expected,
                                  input rvExecPkg::writeback_t actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("Mismatch %s: wb_o expected rd=%0d data=%08h actual rd=%0d data=%08h",
                     name, expected.rd, expected.data, actual.rd, actual.data);
        end
    endtask

    // outputs of the instruction issued one cycle earlier
    task automatic checkSlot();
        checkFlag(pendName, "wbValid_o", pendKind == EXP_WRITE, wbValid);
        checkFlag(pendName, "illegal_o", pendKind == EXP_TRAP, illegal);
        if (pendKind == EXP_WRITE) begin
            checkWriteback(pendName, pendWb, wb);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic issue(input logic [31:0] word, input int kind,
                         input logic [4:0] rd, input logic [31:0] data);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= word;
        @(negedge clk);
        checkSlot();
        pendKind    = kind;
        pendWb.rd   = rd;
        pendWb.data = data;
        pendName    = testName;
        if (kind == EXP_WRITE && rd != 5'd0) begin
            model[rd] = data;   // x0 stays zero
        end
    endtask

    task automatic idle();
        @(posedge clk);
        instrValid <= 1'b0;
        instr      <= '0;
        @(negedge clk);
        checkSlot();
        pendKind = EXP_IDLE;
        pendName = testName;
    endtask

    task automatic opReg(input rvExecPkg::aluOp_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        issue(encodeR(op, rd, rs1, rs2), EXP_WRITE, rd, aluModel(op, model[rs1], model[rs2]));
    endtask

    task automatic opImm(input rvExecPkg::aluOp_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        if (op == rvExecPkg::ALU_SLL || op == rvExecPkg::ALU_SRL || op == rvExecPkg::ALU_SRA) begin
            field = {funct7Of(op), imm[4:0]};   // shamt plus funct7
        end
        issue({field, rs1, funct3Of(op), rd, rvExecPkg::OPC_OP_IMM}, EXP_WRITE, rd,
              aluModel(op, model[rs1], {{20{field[11]}}, field}));
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] upper);
        issue({upper, rd, rvExecPkg::OPC_LUI}, EXP_WRITE, rd, {upper, 12'h000});
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;      // make up for the sign of the low part
        lui(rd, rounded[31:12]);
        opImm(rvExecPkg::ALU_ADD, rd, rd, value[11:0]);
    endtask

    task automatic readReg(input logic [4:0] r);
        opImm(rvExecPkg::ALU_ADD, r, r, 12'h000);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic testReset();
        testName = "reset";
        @(negedge clk);
        checkFlag(testName, "wbValid_o", 1'b0, wbValid);
        checkFlag(testName, "illegal_o", 1'b0, illegal);
        checkWriteback(testName, '0, wb);
    endtask

    task automatic testImmediate();
        rvExecPkg::aluOp_e immOps [0:5] = '{rvExecPkg::ALU_ADD, rvExecPkg::ALU_SLT,
            rvExecPkg::ALU_SLTU, rvExecPkg::ALU_XOR, rvExecPkg::ALU_OR, rvExecPkg::ALU_AND};
        testName = "immediate";
        for (int r = 1; r < 32; r++) begin
            loadReg(5'(r), nextRand());     // whole bank known from here on
        end
        for (int k = 0; k < 4; k++) begin
            foreach (immOps[j]) begin
                opImm(immOps[j], randReg(), randReg(), 12'(nextRand()));
            end
        end
        for (int s = 0; s < 32; s++) begin
            opImm(rvExecPkg::ALU_SLL, randReg(), randReg(), 12'(s));
            opImm(rvExecPkg::ALU_SRL, randReg(), randReg(), 12'(s));
            opImm(rvExecPkg::ALU_SRA, randReg(), randReg(), 12'(s));
        end
        opImm(rvExecPkg::ALU_ADD, 5'd5, 5'd1, 12'h800);    // most negative imm
        opImm(rvExecPkg::ALU_ADD, 5'd5, 5'd1, 12'hFFF);
        opImm(rvExecPkg::ALU_SLTU, 5'd6, 5'd1, 12'hFFF);   // compares with all ones
        opImm(rvExecPkg::ALU_SLT, 5'd6, 5'd1, 12'h800);
        idle();
    endtask

    task automatic testRegister();
        rvExecPkg::aluOp_e regOps [0:9] = '{rvExecPkg::ALU_ADD, rvExecPkg::ALU_SUB,
            rvExecPkg::ALU_SLL, rvExecPkg::ALU_SLT, rvExecPkg::ALU_SLTU, rvExecPkg::ALU_XOR,
            rvExecPkg::ALU_SRL, rvExecPkg::ALU_SRA, rvExecPkg::ALU_OR, rvExecPkg::ALU_AND};
        testName = "register";
        foreach (regOps[j]) begin
            for (int k = 0; k < 6; k++) begin
                opReg(regOps[j], randReg(), randReg(), randReg());
            end
        end
        // signed vs unsigned corners
        loadReg(5'd1, 32'h8000_0000);
        loadReg(5'd2, 32'h0000_0001);
        loadReg(5'd3, 32'hFFFF_FFFF);
        loadReg(5'd4, 32'h7FFF_FFFF);
        loadReg(5'd7, 32'd31);
        loadReg(5'd8, 32'hFFFF_FFE1);   // shift of 1 after masking
        opReg(rvExecPkg::ALU_SLT, 5'd5, 5'd1, 5'd2);
        opReg(rvExecPkg::ALU_SLTU, 5'd5, 5'd1, 5'd2);
        opReg(rvExecPkg::ALU_SLT, 5'd5, 5'd3, 5'd2);
        opReg(rvExecPkg::ALU_SLTU, 5'd5, 5'd3, 5'd2);
        opReg(rvExecPkg::ALU_SLT, 5'd5, 5'd4, 5'd1);
        opReg(rvExecPkg::ALU_SLTU, 5'd5, 5'd4, 5'd1);
        opReg(rvExecPkg::ALU_SRA, 5'd6, 5'd1, 5'd7);
        opReg(rvExecPkg::ALU_SRL, 5'd6, 5'd1, 5'd7);
        opReg(rvExecPkg::ALU_SRA, 5'd6, 5'd3, 5'd8);
        opReg(rvExecPkg::ALU_SRL, 5'd6, 5'd3, 5'd8);
        idle();
    endtask

    task automatic testZeroReg();
        testName = "x0";
        opImm(rvExecPkg::ALU_ADD, 5'd0, 5'd3, 12'h123);    // record shows data, x0 kept
        lui(5'd0, 20'hABCDE);
        readReg(5'd0);
        opReg(rvExecPkg::ALU_ADD, 5'd9, 5'd0, 5'd0);
        opReg(rvExecPkg::ALU_OR, 5'd9, 5'd0, 5'd3);
        idle();
    endtask

    task automatic testBackToBack();
        testName = "back-to-back";
        loadReg(5'd10, nextRand());
        for (int k = 0; k < 4; k++) begin
            opImm(rvExecPkg::ALU_ADD, 5'd11, 5'd10, 12'(nextRand()));
            opReg(rvExecPkg::ALU_XOR, 5'd12, 5'd11, 5'd10);
            opReg(rvExecPkg::ALU_SUB, 5'd10, 5'd12, 5'd11);
        end
        opImm(rvExecPkg::ALU_SRA, 5'd10, 5'd10, 12'd7);
        idle();
    endtask

    task automatic testIllegal();
        logic [31:0] word;
        testName = "illegal";
        loadReg(5'd13, 32'h1234_5678);
        word = encodeR(rvExecPkg::ALU_ADD, 5'd13, 5'd1, 5'd2);
        word[6:0] = 7'b0000011;         // load opcode, not supported
        issue(word, EXP_TRAP, 5'd0, '0);
        word = encodeR(rvExecPkg::ALU_ADD, 5'd13, 5'd1, 5'd2);
        word[31:25] = 7'b0000001;       // mul encoding
        issue(word, EXP_TRAP, 5'd0, '0);
        word = encodeR(rvExecPkg::ALU_XOR, 5'd13, 5'd1, 5'd2);
        word[31:25] = 7'b0100000;
        issue(word, EXP_TRAP, 5'd0, '0);
        issue({7'b0100000, 5'd3, 5'd1, 3'b001, 5'd13, rvExecPkg::OPC_OP_IMM},
              EXP_TRAP, 5'd0, '0);      // slli with alt upper bits
        issue({7'b0000001, 5'd3, 5'd1, 3'b101, 5'd13, rvExecPkg::OPC_OP_IMM},
              EXP_TRAP, 5'd0, '0);
        readReg(5'd13);                 // still the loaded value
        idle();
    endtask

    // ------------------------------------------------------------------------
    // sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        rst        <= 1'b1;
        instrValid <= 1'b0;
        instr      <= '0;
        rngState   = 32'd42429;
        errCount   = 0;
        checkCount = 0;
        pendKind   = EXP_IDLE;
        pendName   = "none";
        testName   = "none";
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testImmediate();
        testRegister();
        testZeroReg();
        testBackToBack();
        testIllegal();
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, testName);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/rvExecPkg.sv
src/RegisterFile.sv
src/InstructionDecoder.sv
src/IntegerAlu.sv
src/ExecuteUnit.sv
verif/ExecuteUnitTb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I execute subsystem

TOP             ?= ExecuteUnitTb
FILELIST        ?= project.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP LOG VERILATOR_FLAGS FILELIST BUILD_DIR VERILATOR"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, no result line"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
